// File: Bender.yml
package:
  name: rename_core

sources:
  - source/core_pkg.sv
  - source/map_table.sv
  - source/free_list.sv
  - source/rename_stage.sv
  - source/rob.sv
  - source/rename_core.sv
  - target: test
    files:
      - verif/rename_core_tb.sv

// File: sim.f
source/core_pkg.sv
source/map_table.sv
source/free_list.sv
source/rename_stage.sv
source/rob.sv
source/rename_core.sv
verif/rename_core_tb.sv

// File: source/core_pkg.sv
/*
 * core package
 * register file sizes, index types and rob entry state
 * shared by every block of the rename core
 */
package core_pkg;

	// ======================================================================
	// sizes
	// ======================================================================
	localparam int AREG_NUM  = 32;                  // architectural regs
	localparam int PREG_NUM  = 48;                  // physical regs
	localparam int ROB_DEPTH = 32;                  // instructions in flight
	localparam int FL_DEPTH  = PREG_NUM - AREG_NUM; // tags unmapped at reset

	// index widths
	localparam int AREG_W = $clog2(AREG_NUM);
	localparam int PREG_W = $clog2(PREG_NUM);
	localparam int ROB_W  = $clog2(ROB_DEPTH);
	localparam int FL_W   = $clog2(FL_DEPTH);

	// occupancy counters need one extra bit to reach full
	localparam int FL_CNT_W  = FL_W + 1;
	localparam int ROB_CNT_W = ROB_W + 1;

	// ======================================================================
	// index types
	// ======================================================================
	typedef logic [AREG_W-1:0] areg_t;    // arch reg index
	typedef logic [PREG_W-1:0] preg_t;    // physical tag
	typedef logic [ROB_W-1:0]  rob_idx_t; // rob entry index
	typedef logic [FL_W-1:0]   fl_ptr_t;  // free list pointer

	// r31 reads as zero and is never renamed
	localparam areg_t ZERO_REG = areg_t'(31);

	// rob entry life cycle
	typedef enum logic [1:0] {
		ROB_EMPTY, // slot free
		ROB_BUSY,  // dispatched and waiting on its unit
		ROB_DONE   // completed and waiting to retire
	} rob_state_e;

endpackage : core_pkg

// File: source/free_list.sv
/*
 * free list
 * circular queue of unmapped physical tags
 * pops at the head on allocation and pushes retired told at the tail
 */
`timescale 1ns/100ps

module free_list (
	input  logic            clk_i,
	input  logic            rst_n_i,

	input  logic            alloc_en_i, // pop head tag

	input  logic            free_en_i,  // push retired tag
	input  core_pkg::preg_t free_tag_i,

	output logic            empty_o,
	output core_pkg::preg_t head_tag_o  // next tag handed out
);

	import core_pkg::*;

	preg_t               fifo_q [FL_DEPTH];
	fl_ptr_t             head_q;
	fl_ptr_t             tail_q;
	logic [FL_CNT_W-1:0] cnt_q;    // tags held

	assign empty_o    = (cnt_q == '0);
	assign head_tag_o = fifo_q[head_q]; // valid only when not empty

	// ======================================================================
	// queue
	// ======================================================================
	// reset queues the 16 unmapped tags 32..47
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < FL_DEPTH; i++) begin
				fifo_q[i] <= preg_t'(AREG_NUM + i);
			end
			head_q <= '0;
			tail_q <= '0; // full list so tail wrapped onto head
			cnt_q  <= FL_CNT_W'(FL_DEPTH);
		end else begin
			if (alloc_en_i) begin
				head_q <= head_q + 1'b1; // pointers wrap at 16
			end
			if (free_en_i) begin
				fifo_q[tail_q] <= free_tag_i;
				tail_q         <= tail_q + 1'b1;
			end
			case ({free_en_i, alloc_en_i})
				2'b10:   cnt_q <= cnt_q + 1'b1;
				2'b01:   cnt_q <= cnt_q - 1'b1;
				default: cnt_q <= cnt_q; // none or both
			endcase
		end
	end

endmodule : free_list

// File: source/map_table.sv
/*
 * map table
 * maps each architectural register to its newest physical tag
 * and keeps a ready bit per register, set by the cdb broadcast
 */
`timescale 1ns/100ps

module map_table (
	input  logic            clk_i,
	input  logic            rst_n_i,

	input  core_pkg::areg_t opa_areg_i,  // source a
	input  core_pkg::areg_t opb_areg_i,  // source b
	input  core_pkg::areg_t dest_areg_i, // destination

	input  logic            rename_en_i, // accepted and writes a reg
	input  core_pkg::preg_t new_tag_i,   // tnew from free list

	input  logic            cdb_vld_i,
	input  core_pkg::preg_t cdb_tag_i,

	output core_pkg::preg_t opa_tag_o,
	output core_pkg::preg_t opb_tag_o,
	output core_pkg::preg_t old_tag_o,   // told to rob
	output logic            opa_rdy_o,
	output logic            opb_rdy_o
);

	import core_pkg::*;

	preg_t               tag_q [AREG_NUM]; // current mapping
	logic [AREG_NUM-1:0] rdy_q;            // value present in prf

	// ======================================================================
	// lookup
	// ======================================================================
	// all reads see the table before this cycle's update
	assign opa_tag_o = tag_q[opa_areg_i];
	assign opb_tag_o = tag_q[opb_areg_i];
	assign old_tag_o = tag_q[dest_areg_i];

	// no forwarding from the cdb of this cycle
	assign opa_rdy_o = rdy_q[opa_areg_i];
	assign opb_rdy_o = rdy_q[opb_areg_i];

	// ======================================================================
	// update
	// ======================================================================
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < AREG_NUM; i++) begin
				tag_q[i] <= preg_t'(i); // identity map
			end
			rdy_q <= '1;
		end else begin
			// wakeup every reg still mapped to the broadcast tag
			for (int i = 0; i < AREG_NUM; i++) begin
				if (cdb_vld_i && (tag_q[i] == cdb_tag_i)) begin
					rdy_q[i] <= 1'b1;
				end
			end
			// rename last so it wins over a stale wakeup
			if (rename_en_i) begin
				tag_q[dest_areg_i] <= new_tag_i;
				rdy_q[dest_areg_i] <= 1'b0; // new producer not done yet
			end
		end
	end

endmodule : map_table

// File: source/rename_core.sv
/*
 * rename core top
 * rename stage and reorder buffer joined by the dispatch,
 * broadcast and free paths
 */
`timescale 1ns/100ps

module rename_core (
	input  logic               clk_i,
	input  logic               rst_n_i,

	// dispatch
	input  logic               dp_vld_i,
	input  core_pkg::areg_t    dp_opa_areg_i,
	input  core_pkg::areg_t    dp_opb_areg_i,
	input  core_pkg::areg_t    dp_dest_areg_i,
	output logic               dp_ack_o,
	output core_pkg::preg_t    dp_opa_tag_o,
	output logic               dp_opa_rdy_o,
	output core_pkg::preg_t    dp_opb_tag_o,
	output logic               dp_opb_rdy_o,
	output core_pkg::preg_t    dp_dest_tag_o,
	output core_pkg::rob_idx_t dp_rob_idx_o,

	// completion from the execution side
	input  logic               cpl_vld_i,
	input  core_pkg::rob_idx_t cpl_rob_idx_i,

	// retirement
	output logic               retire_vld_o,
	output core_pkg::rob_idx_t retire_rob_idx_o,
	output core_pkg::preg_t    retire_tag_o
);

	import core_pkg::*;

	logic  dispatch_en;
	logic  has_dest;
	preg_t new_tag;  // tnew
	preg_t old_tag;  // told
	logic  rob_full;
	logic  cdb_vld;
	preg_t cdb_tag;
	logic  free_en;
	preg_t free_tag;

	// ======================================================================
	// rename stage
	// ======================================================================
	rename_stage u_rename_stage (
		.clk_i          (clk_i),
		.rst_n_i        (rst_n_i),
		.dp_vld_i       (dp_vld_i),
		.dp_opa_areg_i  (dp_opa_areg_i),
		.dp_opb_areg_i  (dp_opb_areg_i),
		.dp_dest_areg_i (dp_dest_areg_i),
		.rob_full_i     (rob_full),
		.cdb_vld_i      (cdb_vld),
		.cdb_tag_i      (cdb_tag),
		.free_en_i      (free_en),
		.free_tag_i     (free_tag),
		.dp_ack_o       (dp_ack_o),
		.dispatch_en_o  (dispatch_en),
		.has_dest_o     (has_dest),
		.new_tag_o      (new_tag),
		.old_tag_o      (old_tag),
		.dp_opa_tag_o   (dp_opa_tag_o),
		.dp_opa_rdy_o   (dp_opa_rdy_o),
		.dp_opb_tag_o   (dp_opb_tag_o),
		.dp_opb_rdy_o   (dp_opb_rdy_o),
		.dp_dest_tag_o  (dp_dest_tag_o)
	);

	// ======================================================================
	// reorder buffer
	// ======================================================================
	rob u_rob (
		.clk_i            (clk_i),
		.rst_n_i          (rst_n_i),
		.dispatch_en_i    (dispatch_en),
		.has_dest_i       (has_dest),
		.new_tag_i        (new_tag),
		.old_tag_i        (old_tag),
		.cpl_vld_i        (cpl_vld_i),
		.cpl_rob_idx_i    (cpl_rob_idx_i),
		.rob_full_o       (rob_full),
		.rob_tail_o       (dp_rob_idx_o), // slot the presented instr gets
		.cdb_vld_o        (cdb_vld),
		.cdb_tag_o        (cdb_tag),
		.free_en_o        (free_en),
		.free_tag_o       (free_tag),
		.retire_vld_o     (retire_vld_o),
		.retire_rob_idx_o (retire_rob_idx_o),
		.retire_tag_o     (retire_tag_o)
	);

endmodule : rename_core

// File: source/rename_stage.sv
/*
 * rename stage
 * decides dispatch acceptance and renames sources and destination
 * through the map table and the free list
 */
`timescale 1ns/100ps

module rename_stage (
	input  logic            clk_i,
	input  logic            rst_n_i,

	input  logic            dp_vld_i,
	input  core_pkg::areg_t dp_opa_areg_i,
	input  core_pkg::areg_t dp_opb_areg_i,
	input  core_pkg::areg_t dp_dest_areg_i,

	input  logic            rob_full_i,

	input  logic            cdb_vld_i,
	input  core_pkg::preg_t cdb_tag_i,

	input  logic            free_en_i,
	input  core_pkg::preg_t free_tag_i,

	output logic            dp_ack_o,
	output logic            dispatch_en_o,
	output logic            has_dest_o,

	output core_pkg::preg_t new_tag_o,  // tnew to rob
	output core_pkg::preg_t old_tag_o,  // told to rob

	output core_pkg::preg_t dp_opa_tag_o,
	output logic            dp_opa_rdy_o,
	output core_pkg::preg_t dp_opb_tag_o,
	output logic            dp_opb_rdy_o,
	output core_pkg::preg_t dp_dest_tag_o
);

	import core_pkg::*;

	logic  has_dest;    // writes a real reg
	logic  fl_empty;
	preg_t fl_head_tag;
	preg_t map_old_tag; // current mapping of dest
	logic  accept;
	logic  alloc_en;
	preg_t dest_tag;

	// ======================================================================
	// acceptance
	// ======================================================================
	assign has_dest = (dp_dest_areg_i != ZERO_REG);

	// a retirement this cycle does not relieve full or empty
	assign accept   = dp_vld_i && !rob_full_i && (!has_dest || !fl_empty);
	assign alloc_en = accept && has_dest;

	// r31 keeps its own tag
	assign dest_tag = has_dest ? fl_head_tag : map_old_tag;

	assign dp_ack_o      = accept;
	assign dispatch_en_o = accept;
	assign has_dest_o    = has_dest;
	assign new_tag_o     = dest_tag;
	assign old_tag_o     = map_old_tag;
	assign dp_dest_tag_o = dest_tag;

	// ======================================================================
	// rename tables
	// ======================================================================
	map_table u_map_table (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.opa_areg_i  (dp_opa_areg_i),
		.opb_areg_i  (dp_opb_areg_i),
		.dest_areg_i (dp_dest_areg_i),
		.rename_en_i (alloc_en),
		.new_tag_i   (fl_head_tag),
		.cdb_vld_i   (cdb_vld_i),
		.cdb_tag_i   (cdb_tag_i),
		.opa_tag_o   (dp_opa_tag_o),
		.opb_tag_o   (dp_opb_tag_o),
		.old_tag_o   (map_old_tag),
		.opa_rdy_o   (dp_opa_rdy_o),
		.opb_rdy_o   (dp_opb_rdy_o)
	);

	free_list u_free_list (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.alloc_en_i (alloc_en),
		.free_en_i  (free_en_i),  // told from retiring rob head
		.free_tag_i (free_tag_i),
		.empty_o    (fl_empty),
		.head_tag_o (fl_head_tag)
	);

endmodule : rename_stage

// File: source/rob.sv
/*
 * reorder buffer
 * records each dispatched instruction, marks completions,
 * drives the cdb broadcast and retires done entries in order
 */
`timescale 1ns/100ps

module rob (
	input  logic               clk_i,
	input  logic               rst_n_i,

	input  logic               dispatch_en_i,
	input  logic               has_dest_i,
	input  core_pkg::preg_t    new_tag_i,
	input  core_pkg::preg_t    old_tag_i,

	input  logic               cpl_vld_i,     // one cycle pulse
	input  core_pkg::rob_idx_t cpl_rob_idx_i,

	output logic               rob_full_o,
	output core_pkg::rob_idx_t rob_tail_o,    // index of next entry

	output logic               cdb_vld_o,
	output core_pkg::preg_t    cdb_tag_o,

	output logic               free_en_o,
	output core_pkg::preg_t    free_tag_o,

	output logic               retire_vld_o,
	output core_pkg::rob_idx_t retire_rob_idx_o,
	output core_pkg::preg_t    retire_tag_o
);

	import core_pkg::*;

	rob_state_e           state_q [ROB_DEPTH];
	preg_t                tnew_q  [ROB_DEPTH]; // tag written
	preg_t                told_q  [ROB_DEPTH]; // tag freed at retire
	logic [ROB_DEPTH-1:0] dest_q;              // entry writes a reg
	rob_idx_t             head_q;
	rob_idx_t             tail_q;
	logic [ROB_CNT_W-1:0] cnt_q;

	logic cpl_hit;  // completion lands on a busy entry
	logic retire;

	// ======================================================================
	// status and broadcast
	// ======================================================================
	assign rob_full_o = (cnt_q == ROB_CNT_W'(ROB_DEPTH));
	assign rob_tail_o = tail_q;

	// stray completions are dropped
	assign cpl_hit   = cpl_vld_i && (state_q[cpl_rob_idx_i] == ROB_BUSY);
	assign cdb_vld_o = cpl_hit && dest_q[cpl_rob_idx_i];
	assign cdb_tag_o = tnew_q[cpl_rob_idx_i];

	// head retires once done
	assign retire           = (state_q[head_q] == ROB_DONE);
	assign retire_vld_o     = retire;
	assign retire_rob_idx_o = head_q;
	assign retire_tag_o     = tnew_q[head_q]; // 31 for an r31 dest
	assign free_en_o        = retire && dest_q[head_q];
	assign free_tag_o       = told_q[head_q];

	// ======================================================================
	// entry state and pointers
	// ======================================================================
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < ROB_DEPTH; i++) begin
				state_q[i] <= ROB_EMPTY;
			end
			head_q <= '0;
			tail_q <= '0;
			cnt_q  <= '0;
		end else begin
			// dispatch, completion and retire never touch one slot at once
			if (dispatch_en_i) begin
				state_q[tail_q] <= ROB_BUSY;
				tail_q          <= tail_q + 1'b1;
			end
			if (cpl_hit) begin
				state_q[cpl_rob_idx_i] <= ROB_DONE;
			end
			if (retire) begin
				state_q[head_q] <= ROB_EMPTY;
				head_q          <= head_q + 1'b1;
			end
			case ({dispatch_en_i, retire})
				2'b10:   cnt_q <= cnt_q + 1'b1;
				2'b01:   cnt_q <= cnt_q - 1'b1;
				default: cnt_q <= cnt_q;
			endcase
		end
	end

	// payload captured at dispatch
	always_ff @(posedge clk_i) begin
		if (dispatch_en_i) begin
			tnew_q[tail_q] <= new_tag_i;
			told_q[tail_q] <= old_tag_i;
			dest_q[tail_q] <= has_dest_i;
		end
	end

endmodule : rob

// File: verif/rename_core_tb.sv
/*
 * rename core testbench
 * directed tests against a cycle model of map table, free list and rob
 * every dispatch, broadcast and retire output is predicted and compared
 */
`timescale 1ns/100ps

module rename_core_tb;

	import core_pkg::*;

	localparam int          CLK_PERIOD      = 8;
	localparam int          RESET_CYCLES    = 16;
	localparam int          WATCHDOG_CYCLES = 4000; // ~250 cycles of tests plus margin
	localparam int unsigned RAND_SEED       = 32'h8c7121d0;

	logic     clk;
	logic     rst_n;
	logic     dp_vld;
	areg_t    dp_opa_areg;
	areg_t    dp_opb_areg;
	areg_t    dp_dest_areg;
	logic     dp_ack;
	preg_t    dp_opa_tag;
	logic     dp_opa_rdy;
	preg_t    dp_opb_tag;
	logic     dp_opb_rdy;
	preg_t    dp_dest_tag;
	rob_idx_t dp_rob_idx;
	logic     cpl_vld;
	rob_idx_t cpl_rob_idx;
	logic     retire_vld;
	rob_idx_t retire_rob_idx;
	preg_t    retire_tag;

	int    err_cnt;
	int    chk_cnt;
	string cur_test;

	// reference model of the state the dut holds this cycle
	preg_t      m_tag   [AREG_NUM];
	logic       m_rdy   [AREG_NUM];
	preg_t      m_free  [$];          // free tags, head first
	rob_state_e m_state [ROB_DEPTH];
	preg_t      m_tnew  [ROB_DEPTH];
	preg_t      m_told  [ROB_DEPTH];
	logic       m_dest  [ROB_DEPTH];
	int         m_head;
	int         m_tail;
	int         m_cnt;

	rename_core u_rename_core (
		.clk_i            (clk),
		.rst_n_i          (rst_n),
		.dp_vld_i         (dp_vld),
		.dp_opa_areg_i    (dp_opa_areg),
		.dp_opb_areg_i    (dp_opb_areg),
		.dp_dest_areg_i   (dp_dest_areg),
		.dp_ack_o         (dp_ack),
		.dp_opa_tag_o     (dp_opa_tag),
		.dp_opa_rdy_o     (dp_opa_rdy),
		.dp_opb_tag_o     (dp_opb_tag),
		.dp_opb_rdy_o     (dp_opb_rdy),
		.dp_dest_tag_o    (dp_dest_tag),
		.dp_rob_idx_o     (dp_rob_idx),
		.cpl_vld_i        (cpl_vld),
		.cpl_rob_idx_i    (cpl_rob_idx),
		.retire_vld_o     (retire_vld),
		.retire_rob_idx_o (retire_rob_idx),
		.retire_tag_o     (retire_tag)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ======================================================================
	// compare tasks
	// ======================================================================
	task automatic check_preg(input string label, input preg_t exp, input preg_t act);
		chk_cnt++;
		if (exp !== act) begin
			err_cnt++;
			$display("Fail %s %s: expected %0d actual %0d", cur_test, label, exp, act);
		end
	endtask

	task automatic check_rob_idx(input string label, input rob_idx_t exp, input rob_idx_t act);
		chk_cnt++;
		if (exp !== act) begin
			err_cnt++;
			$display("Fail %s %s: expected %0d actual %0d", cur_test, label, exp, act);
		end
	endtask

	task automatic check_bit(input string label, input logic exp, input logic act);
		chk_cnt++;
		if (exp !== act) begin
			err_cnt++;
			$display("Fail %s %s: expected %0b actual %0b", cur_test, label, exp, act);
		end
	endtask

	function automatic areg_t pick_any_reg();
		return areg_t'($urandom_range(AREG_NUM - 1, 0));
	endfunction

	function automatic areg_t pick_writable_reg(); // anything but r31
		return areg_t'($urandom_range(AREG_NUM - 2, 0));
	endfunction

	// ======================================================================
	// reset and model
	// ======================================================================
	task automatic apply_reset();
		@(posedge clk);
		rst_n   <= 1'b0;
		dp_vld  <= 1'b0;
		cpl_vld <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		for (int i = 0; i < AREG_NUM; i++) begin
			m_tag[i] = preg_t'(i); // identity map with all ready
			m_rdy[i] = 1'b1;
		end
		m_free.delete();
		for (int i = 0; i < FL_DEPTH; i++) begin
			m_free.push_back(preg_t'(AREG_NUM + i));
		end
		for (int i = 0; i < ROB_DEPTH; i++) begin
			m_state[i] = ROB_EMPTY;
		end
		m_head = 0;
		m_tail = 0;
		m_cnt  = 0;
	endtask

	// one clock cycle that drives at the edge, checks mid cycle and advances the model
	task automatic step(input logic vld, input areg_t ra, input areg_t rb, input areg_t rd,
	                    input logic cv, input rob_idx_t ci);
		logic  has_dest;
		logic  exp_ack;
		logic  hit;
		logic  cdb;
		logic  ret;
		preg_t exp_dest;
		preg_t cdb_tag;
		@(posedge clk);
		dp_vld       <= vld;
		dp_opa_areg  <= ra;
		dp_opb_areg  <= rb;
		dp_dest_areg <= rd;
		cpl_vld      <= cv;
		cpl_rob_idx  <= ci;
		@(negedge clk);
		has_dest = (rd != ZERO_REG);
		exp_ack  = vld && (m_cnt < ROB_DEPTH) && (!has_dest || (m_free.size() > 0));
		exp_dest = has_dest ? ((m_free.size() > 0) ? m_free[0] : '0) : m_tag[ZERO_REG];
		hit      = cv && (m_state[ci] == ROB_BUSY); // stray completions dropped
		cdb      = hit && m_dest[ci];
		cdb_tag  = m_tnew[ci];
		ret      = (m_state[m_head] == ROB_DONE);
		check_bit("dp_ack", exp_ack, dp_ack);
		if (vld) begin
			check_preg("opa_tag", m_tag[ra], dp_opa_tag);
			check_bit("opa_rdy", m_rdy[ra], dp_opa_rdy);
			check_preg("opb_tag", m_tag[rb], dp_opb_tag);
			check_bit("opb_rdy", m_rdy[rb], dp_opb_rdy);
			check_rob_idx("rob_idx", rob_idx_t'(m_tail), dp_rob_idx);
		end
		if (exp_ack) begin
			check_preg("dest_tag", exp_dest, dp_dest_tag);
		end
		check_bit("retire_vld", ret, retire_vld);
		if (ret) begin
			check_rob_idx("retire_idx", rob_idx_t'(m_head), retire_rob_idx);
			check_preg("retire_tag", m_tnew[m_head], retire_tag);
		end
		// state after the coming edge
		if (exp_ack) begin
			m_state[m_tail] = ROB_BUSY;
			m_tnew[m_tail]  = exp_dest;
			m_told[m_tail]  = m_tag[rd];
			m_dest[m_tail]  = has_dest;
			m_tail          = (m_tail + 1) % ROB_DEPTH;
			m_cnt++;
		end
		for (int i = 0; i < AREG_NUM; i++) begin
			if (cdb && (m_tag[i] == cdb_tag)) begin
				m_rdy[i] = 1'b1;
			end
		end
		if (exp_ack && has_dest) begin
			m_tag[rd] = m_free.pop_front();
			m_rdy[rd] = 1'b0; // producer not done yet
		end
		if (hit) begin
			m_state[ci] = ROB_DONE;
		end
		if (ret) begin
			if (m_dest[m_head]) begin
				m_free.push_back(m_told[m_head]); // told back to the tail
			end
			m_state[m_head] = ROB_EMPTY;
			m_head          = (m_head + 1) % ROB_DEPTH;
			m_cnt--;
		end
	endtask

	task automatic idle();
		step(1'b0, '0, '0, '0, 1'b0, '0);
	endtask

	// ======================================================================
	// directed tests
	// ======================================================================
	task automatic test_reset_state();
		areg_t ra;
		areg_t rb;
		cur_test = "reset_state";
		apply_reset();
		idle(); // ack stays low with no valid
		for (int i = 0; i < 8; i++) begin
			ra = pick_any_reg();
			rb = pick_any_reg();
			step(1'b1, ra, rb, ZERO_REG, 1'b0, '0);
			check_preg("identity_a", preg_t'(ra), dp_opa_tag);
			check_preg("identity_b", preg_t'(rb), dp_opb_tag);
			check_bit("ready_a", 1'b1, dp_opa_rdy);
		end
	endtask

	task automatic test_rename_chain();
		areg_t r;
		cur_test = "rename_chain";
		apply_reset();
		r = pick_writable_reg();
		for (int k = 0; k < 5; k++) begin
			step(1'b1, r, r, r, 1'b0, '0); // sources see the previous mapping
			check_preg("chain_tag", preg_t'(AREG_NUM + k), dp_dest_tag);
			check_rob_idx("chain_idx", rob_idx_t'(k), dp_rob_idx);
		end
		step(1'b1, r, ZERO_REG, ZERO_REG, 1'b0, '0);
		check_preg("newest_tag", preg_t'(AREG_NUM + 4), dp_opa_tag);
		check_bit("newest_rdy", 1'b0, dp_opa_rdy);
	endtask

	task automatic test_completion_wakeup();
		areg_t r;
		cur_test = "completion_wakeup";
		apply_reset();
		r = pick_writable_reg();
		step(1'b1, '0, '0, r, 1'b0, '0);              // entry 0 gets tag 32
		step(1'b1, r, r, ZERO_REG, 1'b0, '0);         // reader waits
		step(1'b1, r, r, ZERO_REG, 1'b1, rob_idx_t'(0)); // no bypass this cycle
		check_bit("same_cycle_rdy", 1'b0, dp_opa_rdy);
		step(1'b1, r, r, ZERO_REG, 1'b0, '0);
		check_bit("woken_rdy", 1'b1, dp_opa_rdy);
		check_preg("zero_dest_tag", preg_t'(ZERO_REG), dp_dest_tag);
		step(1'b1, '0, '0, r, 1'b0, '0);
		check_preg("next_free_tag", preg_t'(AREG_NUM + 1), dp_dest_tag); // r31 took none
	endtask

	task automatic test_in_order_retire();
		cur_test = "in_order_retire";
		apply_reset();
		for (int i = 0; i < 4; i++) begin
			step(1'b1, '0, '0, areg_t'(i + 1), 1'b0, '0); // tags 32..35
		end
		step(1'b0, '0, '0, '0, 1'b1, rob_idx_t'(2));  // younger entry completes first
		step(1'b0, '0, '0, '0, 1'b1, rob_idx_t'(0));
		idle();                                        // head retires now
		check_bit("head_retire", 1'b1, retire_vld);
		check_rob_idx("head_idx", rob_idx_t'(0), retire_rob_idx);
		check_preg("head_tnew", preg_t'(AREG_NUM), retire_tag);
		step(1'b0, '0, '0, '0, 1'b1, rob_idx_t'(3));  // entry 1 still busy
		step(1'b0, '0, '0, '0, 1'b1, rob_idx_t'(1));
		repeat (4) idle();                            // 1, 2, 3 drain in order
	endtask

	task automatic test_free_list_full();
		areg_t rd;
		preg_t freed;
		cur_test = "free_list_full";
		apply_reset();
		for (int i = 0; i < FL_DEPTH; i++) begin
			rd = pick_writable_reg();
			if (i == 0) begin
				freed = preg_t'(rd); // reset mapping of the first writer
			end
			step(1'b1, pick_any_reg(), pick_any_reg(), rd, 1'b0, '0);
			check_bit("alloc_ack", 1'b1, dp_ack);
			check_preg("alloc_tag", preg_t'(AREG_NUM + i), dp_dest_tag);
		end
		step(1'b1, '0, '0, ZERO_REG, 1'b0, '0);
		check_bit("zero_accept", 1'b1, dp_ack);
		step(1'b1, '0, '0, areg_t'(5), 1'b0, '0);
		check_bit("empty_refuse", 1'b0, dp_ack);
		step(1'b1, '0, '0, areg_t'(5), 1'b1, rob_idx_t'(0)); // held while entry 0 completes
		step(1'b1, '0, '0, areg_t'(5), 1'b0, '0);     // retire edge leaves the list empty
		check_bit("retire_no_relief", 1'b0, dp_ack);
		step(1'b1, '0, '0, areg_t'(5), 1'b0, '0);
		check_bit("freed_ack", 1'b1, dp_ack);
		check_preg("freed_tag", freed, dp_dest_tag);
	endtask

	task automatic test_rob_full();
		cur_test = "rob_full";
		apply_reset();
		for (int i = 0; i < ROB_DEPTH; i++) begin
			step(1'b1, '0, '0, ZERO_REG, 1'b0, '0);
			check_bit("fill_ack", 1'b1, dp_ack);
		end
		step(1'b1, '0, '0, ZERO_REG, 1'b0, '0);
		check_bit("full_refuse", 1'b0, dp_ack);
		step(1'b1, '0, '0, ZERO_REG, 1'b1, rob_idx_t'(0));
		step(1'b1, '0, '0, ZERO_REG, 1'b0, '0);       // retire does not relieve full
		check_bit("retire_no_relief", 1'b0, dp_ack);
		step(1'b1, '0, '0, ZERO_REG, 1'b0, '0);
		check_bit("slot_ack", 1'b1, dp_ack);
		check_rob_idx("wrapped_idx", rob_idx_t'(0), dp_rob_idx);
		idle();
	endtask

	// ======================================================================
	// main sequence and watchdog
	// ======================================================================
	initial begin
		clk          = 1'b0;
		rst_n        = 1'b0;
		dp_vld       = 1'b0;
		dp_opa_areg  = '0;
		dp_opb_areg  = '0;
		dp_dest_areg = '0;
		cpl_vld      = 1'b0;
		cpl_rob_idx  = '0;
		err_cnt      = 0;
		chk_cnt      = 0;
		void'($urandom(RAND_SEED));
		test_reset_state();
		test_rename_chain();
		test_completion_wakeup();
		test_in_order_retire();
		test_free_list_full();
		test_rob_full();
		$display("checks %0d, errors %0d", chk_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout, the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("sim failed");
		$finish;
	end

endmodule : rename_core_tb
